//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_l2_controller
FILELIST  = all.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)
PASS_MSG  = No errors

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+rtl
rtl/l2_pkg.sv
rtl/l2_request_latch.sv
rtl/l2_tag_store.sv
rtl/l2_lru_ages.sv
rtl/l2_sequencer.sv
rtl/l2_mem_port.sv
rtl/l2_controller.sv
testbench/l2_controller_properties.sv
testbench/tb_l2_controller.sv

//--- rtl/l2_consts.svh
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// cache geometry
`define L2_TAG_W    18
`define L2_INDEX_W  8
`define L2_WAYS     4
`define L2_WAY_W    2

// one age counter per way
`define L2_AGE_W    2

`endif

//--- rtl/l2_controller.sv
`timescale 1ns/1ps

module l2_controller (
    input  logic            clk,
    input  logic            nrst,
    input  logic            rd,
    input  logic            wr,
    input  logic            flush,
    input  l2_pkg::tag_t    tag,
    input  l2_pkg::index_t  index,
    input  logic            mem_ready,
    output logic            busy,
    output logic            done,
    output logic            miss,
    output logic            update,
    output logic            refill,
    output l2_pkg::way_t    way,
    output logic            mem_read,
    output logic            mem_write,
    output l2_pkg::index_t  mem_index,
    output l2_pkg::tag_t    mem_tag
);

    logic            req_write;
    l2_pkg::tag_t    req_tag;
    l2_pkg::index_t  req_index;
    logic            start;
    logic            flush_go;

    logic            hit;
    l2_pkg::way_t    hit_way;
    l2_pkg::way_t    victim_way;
    logic            victim_dirty;
    l2_pkg::tag_t    victim_tag;
    l2_pkg::way_t    oldest_way;

    l2_pkg::way_t    sel_way;
    logic            fill;
    logic            mark_dirty;
    logic            touch;
    logic            start_wb;
    logic            start_fill;
    logic            wb_ack;
    logic            fill_ack;

    l2_request_latch request_latch (
        .clk       (clk),
        .nrst      (nrst),
        .rd        (rd),
        .wr        (wr),
        .tag       (tag),
        .index     (index),
        .busy      (busy),
        .flush     (flush),
        .req_write (req_write),
        .req_tag   (req_tag),
        .req_index (req_index),
        .start     (start),
        .flush_go  (flush_go)
    );

    l2_tag_store tag_store (
        .clk          (clk),
        .nrst         (nrst),
        .req_tag      (req_tag),
        .req_index    (req_index),
        .oldest_way   (oldest_way),
        .fill         (fill),
        .mark_dirty   (mark_dirty),
        .sel_way      (sel_way),
        .flush_go     (flush_go),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // ages follow the way that just hit
    l2_lru_ages lru_ages (
        .clk        (clk),
        .nrst       (nrst),
        .req_index  (req_index),
        .touch      (touch),
        .touch_way  (hit_way),
        .oldest_way (oldest_way)
    );

    l2_sequencer sequencer (
        .clk          (clk),
        .nrst         (nrst),
        .start        (start),
        .req_write    (req_write),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .wb_ack       (wb_ack),
        .fill_ack     (fill_ack),
        .busy         (busy),
        .done         (done),
        .miss         (miss),
        .update       (update),
        .refill       (refill),
        .way          (way),
        .sel_way      (sel_way),
        .fill         (fill),
        .mark_dirty   (mark_dirty),
        .touch        (touch),
        .start_wb     (start_wb),
        .start_fill   (start_fill)
    );

    l2_mem_port mem_port (
        .clk        (clk),
        .nrst       (nrst),
        .start_wb   (start_wb),
        .start_fill (start_fill),
        .req_index  (req_index),
        .req_tag    (req_tag),
        .victim_tag (victim_tag),
        .mem_ready  (mem_ready),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_index  (mem_index),
        .mem_tag    (mem_tag),
        .wb_ack     (wb_ack),
        .fill_ack   (fill_ack)
    );

endmodule

//--- rtl/l2_lru_ages.sv
`timescale 1ns/1ps
`include "l2_consts.svh"

module l2_lru_ages (
    input  logic            clk,
    input  logic            nrst,
    input  l2_pkg::index_t  req_index,
    input  logic            touch,
    input  l2_pkg::way_t    touch_way,
    output l2_pkg::way_t    oldest_way
);

    l2_pkg::age_set_t ages [0:(1 << `L2_INDEX_W)-1];
    l2_pkg::age_set_t cur;

    assign cur = ages[req_index];

    // way whose age has reached the top
    always_comb
    begin
        oldest_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (cur[w] == '1)
                oldest_way = w[`L2_WAY_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            // way w starts with age w
            for (int s = 0; s < (1 << `L2_INDEX_W); s++)
            begin
                for (int w = 0; w < `L2_WAYS; w++)
                    ages[s][w] <= w[`L2_AGE_W-1:0];
            end
        end
        else if (touch)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                if (w[`L2_WAY_W-1:0] == touch_way)
                    ages[req_index][w] <= '0;
                else if (cur[w] < cur[touch_way])
                    ages[req_index][w] <= cur[w] + 1'b1;
            end
        end
    end

endmodule

//--- rtl/l2_mem_port.sv
`timescale 1ns/1ps

module l2_mem_port (
    input  logic            clk,
    input  logic            nrst,
    input  logic            start_wb,
    input  logic            start_fill,
    input  l2_pkg::index_t  req_index,
    input  l2_pkg::tag_t    req_tag,
    input  l2_pkg::tag_t    victim_tag,
    input  logic            mem_ready,
    output logic            mem_read,
    output logic            mem_write,
    output l2_pkg::index_t  mem_index,
    output l2_pkg::tag_t    mem_tag,
    output logic            wb_ack,
    output logic            fill_ack
);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            wb_ack    <= 1'b0;
            fill_ack  <= 1'b0;
        end
        else
        begin
            wb_ack   <= mem_write && mem_ready;
            fill_ack <= mem_read && mem_ready;

            // request held until memory takes it
            if (start_wb)
                mem_write <= 1'b1;
            else if (mem_ready)
                mem_write <= 1'b0;

            if (start_fill)
                mem_read <= 1'b1;
            else if (mem_ready)
                mem_read <= 1'b0;
        end
    end

    // write-back sends the old tag, a fill the new one
    always_ff @(posedge clk)
    begin
        if (start_wb || start_fill)
        begin
            mem_index <= req_index;
            mem_tag   <= start_wb ? victim_tag : req_tag;
        end
    end

endmodule

//--- rtl/l2_pkg.sv
`include "l2_consts.svh"

package l2_pkg;

    typedef logic [`L2_TAG_W-1:0] tag_t;

    typedef logic [`L2_INDEX_W-1:0] index_t;

    typedef logic [`L2_WAY_W-1:0] way_t;

    // field w holds the age of way w, 0 is most recent
    typedef logic [`L2_WAYS-1:0][`L2_AGE_W-1:0] age_set_t;

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_write_back,
        st_allocate
    } l2_state_e;

endpackage

//--- rtl/l2_request_latch.sv
`timescale 1ns/1ps

module l2_request_latch (
    input  logic            clk,
    input  logic            nrst,
    input  logic            rd,
    input  logic            wr,
    input  l2_pkg::tag_t    tag,
    input  l2_pkg::index_t  index,
    input  logic            busy,
    input  logic            flush,
    output logic            req_write,
    output l2_pkg::tag_t    req_tag,
    output l2_pkg::index_t  req_index,
    output logic            start,
    output logic            flush_go
);

    // accept edge for a new request
    assign start = (rd | wr) & ~busy;

    // flush only when idle and nothing else is asked for
    assign flush_go = flush & ~busy & ~(rd | wr);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            req_write <= 1'b0;
        else if (start)
            req_write <= wr;
    end

    // address held for the whole transaction
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            req_tag   <= tag;
            req_index <= index;
        end
    end

endmodule

//--- rtl/l2_sequencer.sv
`timescale 1ns/1ps

module l2_sequencer (
    input  logic          clk,
    input  logic          nrst,
    input  logic          start,
    input  logic          req_write,
    input  logic          hit,
    input  l2_pkg::way_t  hit_way,
    input  l2_pkg::way_t  victim_way,
    input  logic          victim_dirty,
    input  logic          wb_ack,
    input  logic          fill_ack,
    output logic          busy,
    output logic          done,
    output logic          miss,
    output logic          update,
    output logic          refill,
    output l2_pkg::way_t  way,
    output l2_pkg::way_t  sel_way,
    output logic          fill,
    output logic          mark_dirty,
    output logic          touch,
    output logic          start_wb,
    output logic          start_fill
);

    l2_pkg::l2_state_e state;
    l2_pkg::l2_state_e next_state;

    logic in_compare;
    logic compare_miss;

    assign in_compare   = (state == l2_pkg::st_compare);
    assign compare_miss = in_compare && !hit;

    assign busy       = (state != l2_pkg::st_idle);
    assign touch      = in_compare && hit;
    assign mark_dirty = touch && req_write;
    assign fill       = (state == l2_pkg::st_allocate) && fill_ack;

    // memory requests launch on the edge that enters the state
    assign start_wb   = compare_miss && victim_dirty;
    assign start_fill = (compare_miss && !victim_dirty)
                      || ((state == l2_pkg::st_write_back) && wb_ack);

    always_comb
    begin
        next_state = state;
        case (state)
            l2_pkg::st_idle:
                if (start)
                    next_state = l2_pkg::st_compare;
            l2_pkg::st_compare:
                if (hit)
                    next_state = l2_pkg::st_idle;
                else if (victim_dirty)
                    next_state = l2_pkg::st_write_back;
                else
                    next_state = l2_pkg::st_allocate;
            l2_pkg::st_write_back:
                if (wb_ack)
                    next_state = l2_pkg::st_allocate;
            l2_pkg::st_allocate:
                if (fill_ack)
                    next_state = l2_pkg::st_compare;
            default:
                next_state = l2_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state   <= l2_pkg::st_idle;
            done    <= 1'b0;
            miss    <= 1'b0;
            update  <= 1'b0;
            refill  <= 1'b0;
            way     <= '0;
            sel_way <= '0;
        end
        else
        begin
            state  <= next_state;
            done   <= touch;
            miss   <= compare_miss;
            update <= mark_dirty;
            refill <= fill;
            if (touch)
                way <= hit_way;
            // victim kept for the fill
            if (compare_miss)
                sel_way <= victim_way;
        end
    end

endmodule

//--- rtl/l2_tag_store.sv
`timescale 1ns/1ps
`include "l2_consts.svh"

module l2_tag_store (
    input  logic            clk,
    input  logic            nrst,
    input  l2_pkg::tag_t    req_tag,
    input  l2_pkg::index_t  req_index,
    input  l2_pkg::way_t    oldest_way,
    input  logic            fill,
    input  logic            mark_dirty,
    input  l2_pkg::way_t    sel_way,
    input  logic            flush_go,
    output logic            hit,
    output l2_pkg::way_t    hit_way,
    output l2_pkg::way_t    victim_way,
    output logic            victim_dirty,
    output l2_pkg::tag_t    victim_tag
);

    l2_pkg::tag_t tags [0:(`L2_WAYS << `L2_INDEX_W)-1];

    logic [(`L2_WAYS << `L2_INDEX_W)-1:0] valid;
    logic [(`L2_WAYS << `L2_INDEX_W)-1:0] dirty;

    logic [`L2_WAYS-1:0] way_valid;
    logic [`L2_WAYS-1:0] match;

    logic [`L2_INDEX_W+`L2_WAY_W-1:0] fill_addr;
    logic [`L2_INDEX_W+`L2_WAY_W-1:0] hit_addr;
    logic [`L2_INDEX_W+`L2_WAY_W-1:0] victim_addr;

    assign fill_addr   = {req_index, sel_way};
    assign hit_addr    = {req_index, hit_way};
    assign victim_addr = {req_index, victim_way};

    // four-way compare on the current set
    always_comb
    begin
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            way_valid[w] = valid[{req_index, w[`L2_WAY_W-1:0]}];
            match[w] = way_valid[w] && (tags[{req_index, w[`L2_WAY_W-1:0]}] == req_tag);
        end
    end

    assign hit = |match;

    // lowest matching way, lowest invalid way
    always_comb
    begin
        hit_way    = '0;
        victim_way = oldest_way;
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (match[w])
                hit_way = w[`L2_WAY_W-1:0];
            if (!way_valid[w])
                victim_way = w[`L2_WAY_W-1:0];
        end
    end

    assign victim_dirty = dirty[victim_addr];
    assign victim_tag   = tags[victim_addr];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (flush_go)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (fill)
        begin
            valid[fill_addr] <= 1'b1;
            dirty[fill_addr] <= 1'b0;
        end
        else if (mark_dirty)
            dirty[hit_addr] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill)
            tags[fill_addr] <= req_tag;
    end

endmodule

//--- testbench/l2_controller_properties.sv
`timescale 1ns/1ps

module l2_controller_properties (
    input logic clk,
    input logic nrst,
    input logic busy,
    input logic done,
    input logic miss,
    input logic mem_read,
    input logic mem_write,
    input logic mem_ready
);

    // one direction toward memory at a time
    one_mem_dir: assert property (@(posedge clk) disable iff (!nrst)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    miss_not_done: assert property (@(posedge clk) disable iff (!nrst)
        !(miss && done))
        else $error("miss and done are high together");

    // requests wait for memory
    read_held: assert property (@(posedge clk) disable iff (!nrst)
        (mem_read && !mem_ready) |=> mem_read)
        else $error("mem_read dropped before mem_ready");

    write_held: assert property (@(posedge clk) disable iff (!nrst)
        (mem_write && !mem_ready) |=> mem_write)
        else $error("mem_write dropped before mem_ready");

    done_idle: assert property (@(posedge clk) disable iff (!nrst)
        done |-> !busy)
        else $error("busy still high with done");

endmodule

bind l2_controller l2_controller_properties properties (
    .clk       (clk),
    .nrst      (nrst),
    .busy      (busy),
    .done      (done),
    .miss      (miss),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_ready (mem_ready)
);

//--- testbench/tb_l2_controller.sv
`timescale 1ns/1ps
`include "l2_consts.svh"

module tb_l2_controller;

    localparam int num_requests = 400;
    localparam int reset_cycles = 10;
    // slowest miss (write-back plus fill, both slow) needs about 14 cycles
    localparam int max_cycles = num_requests * 16 + reset_cycles;

    logic           clk;
    logic           nrst;
    logic           rd;
    logic           wr;
    logic           flush;
    l2_pkg::tag_t   tag;
    l2_pkg::index_t index;
    logic           mem_ready;
    logic           busy;
    logic           done;
    logic           miss;
    logic           update;
    logic           refill;
    l2_pkg::way_t   way;
    logic           mem_read;
    logic           mem_write;
    l2_pkg::index_t mem_index;
    l2_pkg::tag_t   mem_tag;

    int seed;
    int mem_seed;
    int cycles;
    int ready_wait;

    // reference copy of every line
    logic                 model_valid [0:(1 << `L2_INDEX_W)-1][0:`L2_WAYS-1];
    logic                 model_dirty [0:(1 << `L2_INDEX_W)-1][0:`L2_WAYS-1];
    l2_pkg::tag_t         model_tag   [0:(1 << `L2_INDEX_W)-1][0:`L2_WAYS-1];
    logic [`L2_AGE_W-1:0] model_age   [0:(1 << `L2_INDEX_W)-1][0:`L2_WAYS-1];

    l2_controller DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    // memory answers after 0 to 3 cycles, own random stream
    initial
    begin
        mem_seed = 32'h8a30_5617;
        mem_ready = 1'b0;
        ready_wait = -1;
        forever
        begin
            @(posedge clk);
            #2;
            if (mem_ready)
                mem_ready = 1'b0;
            else if (mem_read || mem_write)
            begin
                if (ready_wait < 0)
                    ready_wait = $unsigned($random(mem_seed)) % 4;
                if (ready_wait == 0)
                    mem_ready = 1'b1;
                ready_wait--;
            end
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < max_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        abort_run();
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_way(input string name, input l2_pkg::way_t actual,
                             input l2_pkg::way_t expected);
        if (actual !== expected)
        begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_tag(input string name, input l2_pkg::tag_t actual,
                             input l2_pkg::tag_t expected);
        if (actual !== expected)
        begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_index(input string name, input l2_pkg::index_t actual,
                               input l2_pkg::index_t expected);
        if (actual !== expected)
        begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    function automatic l2_pkg::tag_t tag_of(input int slot, input int pick);
        return {10'h2d1, slot[1:0], pick[5:0]};
    endfunction

    function automatic l2_pkg::index_t index_of(input int slot);
        return l2_pkg::index_t'(slot * 85);
    endfunction

    function automatic void clear_lines();
        for (int s = 0; s < (1 << `L2_INDEX_W); s++)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
            end
        end
    endfunction

    function automatic int find_way(input int s, input l2_pkg::tag_t t);
        int found;
        found = -1;
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (model_valid[s][w] && model_tag[s][w] == t)
                found = w;
        end
        return found;
    endfunction

    // first free way, else the one unused for longest
    function automatic int pick_victim(input int s);
        int v;
        v = -1;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (v < 0 && !model_valid[s][w])
                v = w;
        end
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (v < 0 && model_age[s][w] == '1)
                v = w;
        end
        return v;
    endfunction

    function automatic void touch_ages(input int s, input int w);
        logic [`L2_AGE_W-1:0] a;
        a = model_age[s][w];
        for (int v = 0; v < `L2_WAYS; v++)
        begin
            if (v == w)
                model_age[s][v] = '0;
            else if (model_age[s][v] < a)
                model_age[s][v] = model_age[s][v] + 1'b1;
        end
    endfunction

    task automatic run_flush();
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        check_bit("busy", busy, 1'b0);
        clear_lines();
    endtask

    task automatic run_request(input logic write, input l2_pkg::tag_t t,
                               input l2_pkg::index_t i);
        int s;
        int v;
        int cyc;
        logic exp_hit;
        logic exp_wb;
        logic finished;
        logic saw_wb;
        logic saw_rd;
        logic saw_refill;
        l2_pkg::way_t exp_way;
        l2_pkg::tag_t wb_tag;
        s = int'(i);
        v = find_way(s, t);
        exp_hit = (v >= 0);
        if (!exp_hit)
            v = pick_victim(s);
        exp_way = l2_pkg::way_t'(v);
        exp_wb = !exp_hit && model_valid[s][v] && model_dirty[s][v];
        wb_tag = model_tag[s][v];
        // a miss refills the line, then ends as a hit
        if (!exp_hit)
        begin
            model_tag[s][v] = t;
            model_valid[s][v] = 1'b1;
            model_dirty[s][v] = 1'b0;
        end
        touch_ages(s, v);
        if (write)
            model_dirty[s][v] = 1'b1;

        check_bit("busy", busy, 1'b0);
        rd = ~write;
        wr = write;
        tag = t;
        index = i;
        @(posedge clk);
        #2;
        rd = 1'b0;
        wr = 1'b0;
        cyc = 0;
        finished = 1'b0;
        saw_wb = 1'b0;
        saw_rd = 1'b0;
        saw_refill = 1'b0;
        while (!finished)
        begin
            @(negedge clk);
            cyc++;
            check_bit("miss", miss, (cyc == 2) && !exp_hit);
            check_bit("update", update, done && write);
            check_bit("busy", busy, !done);
            if (mem_write)
            begin
                check_bit("mem_write", mem_write, exp_wb);
                check_index("mem_index", mem_index, i);
                check_tag("mem_tag", mem_tag, wb_tag);
                saw_wb = 1'b1;
            end
            if (mem_read)
            begin
                check_bit("mem_read", mem_read, !exp_hit);
                check_bit("write-back seen before fill", saw_wb, exp_wb);
                check_index("mem_index", mem_index, i);
                check_tag("mem_tag", mem_tag, t);
                saw_rd = 1'b1;
            end
            if (refill)
            begin
                check_bit("refill", refill, !exp_hit);
                saw_refill = 1'b1;
            end
            finished = done;
        end
        check_way("way", way, exp_way);
        if (exp_hit && cyc != 2)
        begin
            $display("Hit request took %0d cycles to finish instead of 2", cyc);
            abort_run();
        end
        if (!exp_hit)
        begin
            check_bit("refill seen", saw_refill, 1'b1);
            check_bit("mem_read seen", saw_rd, 1'b1);
            check_bit("mem_write seen", saw_wb, exp_wb);
        end
        @(posedge clk);
        #2;
    endtask

    initial
    begin
        int rnd;
        int slot;
        int pick;
        seed = 32'h8a30_5617;
        nrst = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        flush = 1'b0;
        tag = '0;
        index = '0;
        clear_lines();
        for (int s = 0; s < (1 << `L2_INDEX_W); s++)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                model_tag[s][w] = '0;
                model_age[s][w] = w[`L2_AGE_W-1:0];
            end
        end
        repeat (reset_cycles) @(posedge clk);
        #2;
        nrst = 1'b1;
        @(posedge clk);
        #2;
        // 4 sets with 6 tags each keep evictions frequent
        for (int n = 0; n < num_requests; n++)
        begin
            rnd = $random(seed);
            slot = $unsigned(rnd) % 4;
            pick = ($unsigned(rnd) >> 2) % 6;
            if ((($unsigned(rnd) >> 8) % 32) == 0)
                run_flush();
            run_request(rnd[31], tag_of(slot, pick), index_of(slot));
        end
        $display("No errors");
        $finish;
    end

endmodule
